// ==== sources.f ====
design/conv_pkg.sv
design/step_buffer.sv
design/conv_datapath.sv
design/output_chain.sv
design/conv_unit.sv
verification/conv_unit_props.sv
verification/conv_unit_checker.sv
verification/conv_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= conv_unit_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ** PASS **

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/conv_unit_tb.sv ====
/*
 * testbench of the convolution unit
 *   clock, reset, seeded random blocks with input gaps and back-pressure
 *   reference model of the per-lane block sums
 *   six tests, then the closing summary and verdict
 */

`timescale 1ns/1ps

module conv_unit_tb import conv_pkg::*; ();

    localparam int KERNEL_W   = DEFAULT_KERNEL_W;
    localparam int STEP_DELAY = DEFAULT_STEP_DELAY;
    localparam int MUL_DELAY  = DEFAULT_MUL_DELAY;
    // shortest block that keeps results apart in the output chain
    localparam int MIN_LEN    = KERNEL_W * STEP_DELAY;
    localparam int MAX_LEN    = 20;
    localparam pixel_t  PIXEL_MIN  = {1'b1, {(PIXEL_WIDTH-1){1'b0}}};
    localparam weight_t WEIGHT_MIN = {1'b1, {(WEIGHT_WIDTH-1){1'b0}}};
    localparam weight_t WEIGHT_MAX = {1'b0, {(WEIGHT_WIDTH-1){1'b1}}};

    logic    aclk = 1'b0;
    logic    reset;
    logic    s_valid;
    pixel_t  s_pixel;
    weight_t s_weights [KERNEL_W-1:0];
    logic    s_last;
    user_t   s_user;
    logic    s_ready;
    logic    m_valid;
    sum_t    m_data;
    logic    m_last;
    user_t   m_user;
    logic    m_ready;
    int      pending;
    int      run_failed;
    integer  seed = 32'h354d_6fdc;
    // running sum per lane of the block being sent
    sum_t    model_acc [KERNEL_W-1:0];

    always #10 aclk = ~aclk;

    conv_unit #(
        .KERNEL_W   (KERNEL_W),
        .STEP_DELAY (STEP_DELAY),
        .MUL_DELAY  (MUL_DELAY)
    ) uut (
        .aclk      (aclk),
        .reset     (reset),
        .s_valid   (s_valid),
        .s_pixel   (s_pixel),
        .s_weights (s_weights),
        .s_last    (s_last),
        .s_user    (s_user),
        .s_ready   (s_ready),
        .m_valid   (m_valid),
        .m_data    (m_data),
        .m_last    (m_last),
        .m_user    (m_user),
        .m_ready   (m_ready)
    );

    conv_unit_checker chk (
        .aclk    (aclk),
        .reset   (reset),
        .m_valid (m_valid),
        .m_data  (m_data),
        .m_last  (m_last),
        .m_user  (m_user),
        .m_ready (m_ready),
        .pending (pending)
    );

    function automatic logic [31:0] next_word();
        return $random(seed);
    endfunction

    function automatic int uniform_below(input int n);
        logic [31:0] w;
        w = next_word();
        return int'(w[30:0]) % n;
    endfunction

    function automatic int block_length();
        return MIN_LEN + uniform_below(MAX_LEN - MIN_LEN + 1);
    endfunction

    // one block of len accepted beats
    // in extreme mode the minimum pixel meets a fixed min or max weight per lane
    task automatic send_block(input int len, input int gap_pct, input int stall_pct,
                              input bit extreme);
        logic [31:0] w;
        user_t       tag;
        weight_t     fixed_w [KERNEL_W-1:0];
        int          beats;
        int          cycles;
        w = next_word();
        tag = w[USER_WIDTH-1:0];
        for (int k = 0; k < KERNEL_W; k++) begin
            fixed_w[k] = (uniform_below(2) == 0) ? WEIGHT_MIN : WEIGHT_MAX;
            model_acc[k] = '0;
        end
        beats = 0;
        cycles = 0;
        while (beats < len && cycles < len * 8 + 100) begin
            m_ready = uniform_below(100) >= stall_pct;
            s_valid = uniform_below(100) >= gap_pct;
            w = next_word();
            s_pixel = extreme ? PIXEL_MIN : w[PIXEL_WIDTH-1:0];
            s_last = (beats == len - 1);
            // only the last beat carries the block tag
            s_user = s_last ? tag : w[PIXEL_WIDTH +: USER_WIDTH];
            for (int k = 0; k < KERNEL_W; k++) begin
                w = next_word();
                s_weights[k] = extreme ? fixed_w[k] : w[WEIGHT_WIDTH-1:0];
            end
            @(posedge aclk);
            // model takes the same beat and wraps at 32 bits
            if (s_valid && m_ready) begin
                for (int k = 0; k < KERNEL_W; k++) begin
                    model_acc[k] = model_acc[k] + sum_t'(s_pixel) * sum_t'(s_weights[k]);
                end
                beats++;
            end
            cycles++;
            #1;
        end
        s_valid = 1'b0;
        s_last = 1'b0;
        if (beats < len) begin
            chk.note_failure("timeout while sending a block, its beats were not accepted");
        end else begin
            // results leave in lane order with the last flag on the final lane
            for (int k = 0; k < KERNEL_W; k++) begin
                chk.push_expected(model_acc[k], k == KERNEL_W - 1, tag);
            end
        end
    endtask

    // run until every expected beat has come out and then idle for settle cycles
    task automatic drain(input int stall_pct, input int settle);
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < 500) begin
            m_ready = uniform_below(100) >= stall_pct;
            @(posedge aclk);
            #1;
            cycles++;
        end
        if (pending != 0) begin
            chk.note_failure("timeout while draining, expected output beats never arrived");
        end
        // idle cycles in which a surplus beat would come out
        repeat (settle) begin
            m_ready = uniform_below(100) >= stall_pct;
            @(posedge aclk);
            #1;
        end
        m_ready = 1'b1;
    endtask

    initial begin
        reset = 1'b1;
        s_valid = 1'b0;
        s_pixel = '0;
        s_last = 1'b0;
        s_user = '0;
        m_ready = 1'b1;
        for (int k = 0; k < KERNEL_W; k++) begin
            s_weights[k] = '0;
        end
        repeat (5) @(posedge aclk);
        #1;
        reset = 1'b0;

        send_block(block_length(), 0, 0, 1'b0);
        drain(0, 0);
        chk.end_test("single block, no stalls");

        repeat (4) send_block(block_length(), 0, 0, 1'b0);
        drain(0, 0);
        chk.end_test("tag and last");

        repeat (12) send_block(block_length(), 30, 0, 1'b0);
        drain(0, 0);
        chk.end_test("back-to-back blocks with input gaps");

        repeat (12) send_block(block_length(), 20, 40, 1'b0);
        drain(40, 0);
        chk.end_test("random back-pressure");

        // long enough that every lane sum passes 2^32
        send_block(270000, 0, 0, 1'b1);
        send_block(270000, 10, 20, 1'b1);
        drain(0, 0);
        chk.end_test("wrap-around");

        repeat (6) send_block(block_length(), 20, 30, 1'b0);
        drain(30, 50);
        chk.end_test("drain");

        chk.report_totals(uut.props.assert_failures, run_failed);
        if (run_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verification/conv_unit_checker.sv ====
/*
 * output monitor of the convolution unit
 *   ring of expected beats filled by the reference model
 *   compares data, last and tag of every accepted output beat
 *   per-test lines and the closing counts
 */

`timescale 1ns/1ps

module conv_unit_checker import conv_pkg::*; (
    input  logic  aclk,
    input  logic  reset,
    input  logic  m_valid,
    input  sum_t  m_data,
    input  logic  m_last,
    input  user_t m_user,
    input  logic  m_ready,
    output int    pending
);

    localparam int EXP_DEPTH = 64;

    // expected beats, written at pushed, read at popped
    sum_t  exp_data [EXP_DEPTH];
    logic  exp_last [EXP_DEPTH];
    user_t exp_user [EXP_DEPTH];
    int    pushed = 0;
    int    popped = 0;
    int    received = 0;
    int    check_errors = 0;
    int    other_errors = 0;
    // per-test bookkeeping
    int    tests_run = 0;
    int    tests_failed = 0;
    int    mark_beats = 0;
    int    mark_errors = 0;

    assign pending = pushed - popped;

    task automatic push_expected(input sum_t data, input logic last, input user_t user);
        exp_data[pushed % EXP_DEPTH] = data;
        exp_last[pushed % EXP_DEPTH] = last;
        exp_user[pushed % EXP_DEPTH] = user;
        pushed = pushed + 1;
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        other_errors = other_errors + 1;
    endtask

    // output beat taken when valid and ready meet at the edge
    always @(posedge aclk) begin
        int slot;
        int bad;
        if (!reset && m_valid && m_ready) begin
            received <= received + 1;
            if (pushed == popped) begin
                $display("unexpected output beat 0x%08h, the model expected nothing", m_data);
                check_errors <= check_errors + 1;
            end else begin
                slot = popped % EXP_DEPTH;
                bad = 0;
                if (m_data !== exp_data[slot]) begin
                    $display("[ERROR] m_data: got 0x%08h, expected 0x%08h",
                             m_data, exp_data[slot]);
                    bad++;
                end
                if (m_last !== exp_last[slot]) begin
                    $display("[ERROR] m_last: got 0x%0h, expected 0x%0h", m_last, exp_last[slot]);
                    bad++;
                end
                if (m_user !== exp_user[slot]) begin
                    $display("[ERROR] m_user: got 0x%0h, expected 0x%0h", m_user, exp_user[slot]);
                    bad++;
                end
                popped <= popped + 1;
                check_errors <= check_errors + bad;
            end
        end
    end

    task automatic end_test(input string name);
        int beats;
        int errs;
        beats = received - mark_beats;
        errs = check_errors + other_errors - mark_errors;
        tests_run = tests_run + 1;
        if (errs != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("test %0d, %s: %0d beats, %0d errors, %s",
                 tests_run, name, beats, errs, (errs == 0) ? "ok" : "failed");
        mark_beats = received;
        mark_errors = check_errors + other_errors;
    endtask

    task automatic report_totals(input int assert_fails, output int failed);
        int errs;
        errs = check_errors + other_errors;
        $display("tests %0d, failed %0d, beats %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, received, errs, assert_fails);
        failed = (errs != 0 || assert_fails != 0 || tests_failed != 0) ? 1 : 0;
    endtask

endmodule

// ==== verification/conv_unit_props.sv ====
/*
 * concurrent assertions on the convolution unit top level
 *   m_valid cleared in the cycle after reset
 *   outputs hold while a beat waits on m_ready
 *   s_ready follows m_ready
 */

`timescale 1ns/1ps

module conv_unit_props import conv_pkg::*; (
    input logic  aclk,
    input logic  reset,
    input logic  s_ready,
    input logic  m_valid,
    input sum_t  m_data,
    input logic  m_last,
    input user_t m_user,
    input logic  m_ready
);

    // number of failed assertions so far
    int assert_failures = 0;

    reset_clears_valid: assert property (@(posedge aclk) reset |=> !m_valid)
        else begin
            $error("m_valid is high in the cycle after reset");
            assert_failures = assert_failures + 1;
        end

    // frozen unit, the pending beat stays as it is
    stall_holds_output: assert property (@(posedge aclk) disable iff (reset)
        (m_valid && !m_ready) |=>
            (m_valid && $stable(m_data) && $stable(m_last) && $stable(m_user)))
        else begin
            $error("output beat changed while m_ready was low");
            assert_failures = assert_failures + 1;
        end

    ready_follows: assert property (@(posedge aclk) s_ready == m_ready)
        else begin
            $error("s_ready differs from m_ready");
            assert_failures = assert_failures + 1;
        end

endmodule

bind conv_unit conv_unit_props props (
    .aclk    (aclk),
    .reset   (reset),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_last  (m_last),
    .m_user  (m_user),
    .m_ready (m_ready)
);

// ==== design/conv_unit.sv ====
/*
 * top level of the integer convolution unit
 *   pixel and weight step buffers
 *   KERNEL_W multiply-accumulate datapaths
 *   output shift chain, m_ready freezes the whole unit
 */

`timescale 1ns/1ps

module conv_unit import conv_pkg::*; #(
    parameter int KERNEL_W   = DEFAULT_KERNEL_W,
    parameter int STEP_DELAY = DEFAULT_STEP_DELAY,
    parameter int MUL_DELAY  = DEFAULT_MUL_DELAY
)(
    input  logic    aclk,
    input  logic    reset,

    input  logic    s_valid,
    input  pixel_t  s_pixel,
    input  weight_t s_weights [KERNEL_W-1:0],
    input  logic    s_last,
    input  user_t   s_user,
    output logic    s_ready,

    output logic    m_valid,
    output sum_t    m_data,
    output logic    m_last,
    output user_t   m_user,
    input  logic    m_ready
);

    // broadcast inputs of the step buffers
    logic        lane_valid     [KERNEL_W-1:0];
    pixel_lane_t lane_pixel     [KERNEL_W-1:0];

    // staggered lanes
    logic        buf_pix_valid  [KERNEL_W-1:0];
    pixel_lane_t buf_pixel      [KERNEL_W-1:0];
    logic        buf_wgt_valid  [KERNEL_W-1:0];
    weight_t     buf_weight     [KERNEL_W-1:0];

    // per lane block results
    logic        res_valid      [KERNEL_W-1:0];
    sum_t        res_sum        [KERNEL_W-1:0];
    user_t       res_user       [KERNEL_W-1:0];

    // no handshake of its own, the unit runs whenever downstream is ready
    assign s_ready = m_ready;

    genvar k;
    generate
        for (k = 0; k < KERNEL_W; k++) begin : lane_gen
            // same pixel beat goes to every lane
            assign lane_valid[k] = s_valid;
            assign lane_pixel[k] = '{pixel: s_pixel, last: s_last, user: s_user};
        end
    endgenerate

    // pixel lanes
    step_buffer #(
        .payload_t  (pixel_lane_t),
        .STEPS      (KERNEL_W),
        .STEP_DELAY (STEP_DELAY)
    ) pixel_buffer (
        .aclk        (aclk),
        .reset       (reset),
        .enable      (m_ready),
        .in_valid    (lane_valid),
        .in_payload  (lane_pixel),
        .out_valid   (buf_pix_valid),
        .out_payload (buf_pixel)
    );

    // weight lanes, one weight per lane
    step_buffer #(
        .payload_t  (weight_t),
        .STEPS      (KERNEL_W),
        .STEP_DELAY (STEP_DELAY)
    ) weight_buffer (
        .aclk        (aclk),
        .reset       (reset),
        .enable      (m_ready),
        .in_valid    (lane_valid),
        .in_payload  (s_weights),
        .out_valid   (buf_wgt_valid),
        .out_payload (buf_weight)
    );

    generate
        for (k = 0; k < KERNEL_W; k++) begin : datapath_gen
            conv_datapath #(
                .MUL_DELAY (MUL_DELAY)
            ) datapath (
                .aclk         (aclk),
                .reset        (reset),
                .enable       (m_ready),
                .pixel_valid  (buf_pix_valid[k]),
                .pixel_lane   (buf_pixel[k]),
                .weight_valid (buf_wgt_valid[k]),
                .weight       (buf_weight[k]),
                .res_valid    (res_valid[k]),
                .res_sum      (res_sum[k]),
                .res_user     (res_user[k])
            );
        end
    endgenerate

    // merges lane results into one stream, lane 0 first
    output_chain #(
        .KERNEL_W (KERNEL_W)
    ) chain (
        .aclk      (aclk),
        .reset     (reset),
        .enable    (m_ready),
        .res_valid (res_valid),
        .res_sum   (res_sum),
        .res_user  (res_user),
        .m_valid   (m_valid),
        .m_data    (m_data),
        .m_last    (m_last),
        .m_user    (m_user)
    );

endmodule

// ==== design/output_chain.sv ====
/*
 * output shift chain of the convolution unit
 *   KERNEL_W registers, register k can take lane k's result
 *   otherwise each register takes the one before it
 *   last flag set only on the result of the final lane
 */

`timescale 1ns/1ps

module output_chain import conv_pkg::*; #(
    parameter int KERNEL_W = DEFAULT_KERNEL_W
)(
    input  logic  aclk,
    input  logic  reset,
    input  logic  enable,

    input  logic  res_valid [KERNEL_W-1:0],
    input  sum_t  res_sum   [KERNEL_W-1:0],
    input  user_t res_user  [KERNEL_W-1:0],

    output logic  m_valid,
    output sum_t  m_data,
    output logic  m_last,
    output user_t m_user
);

    // chain registers, index KERNEL_W-1 drives the outputs
    logic  chain_valid [KERNEL_W-1:0];
    sum_t  chain_data  [KERNEL_W-1:0];
    logic  chain_last  [KERNEL_W-1:0];
    user_t chain_user  [KERNEL_W-1:0];

    genvar k;
    generate
        for (k = 0; k < KERNEL_W; k++) begin : stage_gen
            // insertion flag for this stage
            localparam logic IS_LAST = (k == KERNEL_W - 1);

            if (k == 0) begin : head_gen
                // head of the chain only ever sees lane 0
                always_ff @(posedge aclk) begin
                    if (reset) begin
                        chain_valid[k] <= 1'b0;
                    end else if (enable) begin
                        chain_valid[k] <= res_valid[k];
                    end
                end

                always_ff @(posedge aclk) begin
                    if (enable && res_valid[k]) begin
                        chain_data[k] <= res_sum[k];
                        chain_last[k] <= IS_LAST;
                        chain_user[k] <= res_user[k];
                    end
                end
            end else begin : body_gen
                // lane result wins, else shift from stage k-1
                always_ff @(posedge aclk) begin
                    if (reset) begin
                        chain_valid[k] <= 1'b0;
                    end else if (enable) begin
                        chain_valid[k] <= res_valid[k] | chain_valid[k-1];
                    end
                end

                always_ff @(posedge aclk) begin
                    if (enable) begin
                        if (res_valid[k]) begin
                            chain_data[k] <= res_sum[k];
                            chain_last[k] <= IS_LAST;
                            chain_user[k] <= res_user[k];
                        end else begin
                            chain_data[k] <= chain_data[k-1];
                            chain_last[k] <= chain_last[k-1];
                            chain_user[k] <= chain_user[k-1];
                        end
                    end
                end
            end
        end
    endgenerate

    // tail of the chain, held while enable is low
    assign m_valid = chain_valid[KERNEL_W-1];
    assign m_data  = chain_data[KERNEL_W-1];
    assign m_last  = chain_last[KERNEL_W-1];
    assign m_user  = chain_user[KERNEL_W-1];

endmodule

// ==== design/conv_datapath.sv ====
/*
 * one datapath of the convolution unit
 *   signed multiplier, MUL_DELAY pipeline stages
 *   block accumulator, restarts after each last beat
 *   result pulse with the finished sum and the block tag
 */

`timescale 1ns/1ps

module conv_datapath import conv_pkg::*; #(
    parameter int MUL_DELAY = DEFAULT_MUL_DELAY
)(
    input  logic        aclk,
    input  logic        reset,
    input  logic        enable,

    input  logic        pixel_valid,
    input  pixel_lane_t pixel_lane,
    input  logic        weight_valid,
    input  weight_t     weight,

    output logic        res_valid,
    output sum_t        res_sum,
    output user_t       res_user
);

    // full precision product of pixel and weight
    localparam int PROD_WIDTH = PIXEL_WIDTH + WEIGHT_WIDTH;

    // beat entering the multiplier
    logic                         beat_valid;
    logic signed [PROD_WIDTH-1:0] beat_prod;

    // multiplier pipeline, stage MUL_DELAY-1 feeds the accumulator
    logic                         mul_valid [MUL_DELAY-1:0];
    logic signed [PROD_WIDTH-1:0] mul_prod  [MUL_DELAY-1:0];
    logic                         mul_last  [MUL_DELAY-1:0];
    user_t                        mul_user  [MUL_DELAY-1:0];

    // accumulator side
    logic                         acc_in_valid;
    logic                         acc_in_last;
    user_t                        acc_in_user;
    sum_t                         prod_ext;
    sum_t                         acc;
    // set while the next product opens a new block
    logic                         block_start;

    // a beat counts only when both lanes carry data
    assign beat_valid = pixel_valid & weight_valid;
    assign beat_prod  = $signed(pixel_lane.pixel) * $signed(weight);

    // valid bits of the multiplier stages
    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < MUL_DELAY; i++) begin
                mul_valid[i] <= 1'b0;
            end
        end else if (enable) begin
            mul_valid[0] <= beat_valid;
            for (int i = 1; i < MUL_DELAY; i++) begin
                mul_valid[i] <= mul_valid[i-1];
            end
        end
    end

    // product, last and tag ride along with the valid bit
    always_ff @(posedge aclk) begin
        if (enable) begin
            mul_prod[0] <= beat_prod;
            mul_last[0] <= pixel_lane.last;
            mul_user[0] <= pixel_lane.user;
            for (int i = 1; i < MUL_DELAY; i++) begin
                mul_prod[i] <= mul_prod[i-1];
                mul_last[i] <= mul_last[i-1];
                mul_user[i] <= mul_user[i-1];
            end
        end
    end

    // tail of the multiplier pipeline
    assign acc_in_valid = mul_valid[MUL_DELAY-1];
    assign acc_in_last  = mul_last[MUL_DELAY-1];
    assign acc_in_user  = mul_user[MUL_DELAY-1];
    // sign extend to the accumulator width
    assign prod_ext     = sum_t'(mul_prod[MUL_DELAY-1]);

    // accumulator control
    always_ff @(posedge aclk) begin
        if (reset) begin
            block_start <= 1'b1;
            res_valid   <= 1'b0;
        end else if (enable) begin
            // one cycle pulse, together with the final sum
            res_valid <= acc_in_valid & acc_in_last;
            if (acc_in_valid) begin
                block_start <= acc_in_last;
            end
        end
    end

    // running sum, wraps modulo 2^SUM_WIDTH
    always_ff @(posedge aclk) begin
        if (enable && acc_in_valid) begin
            if (block_start) begin
                acc <= prod_ext;
            end else begin
                acc <= acc + prod_ext;
            end
            // tag of the block is taken from its last beat
            if (acc_in_last) begin
                res_user <= acc_in_user;
            end
        end
    end

    // sum is complete in the cycle res_valid is high
    assign res_sum = acc;

endmodule

// ==== design/step_buffer.sv ====
/*
 * staggered delay lines for the lanes of the convolution unit
 *   lane k is delayed by k x STEP_DELAY enabled cycles
 *   lane 0 passes straight through
 *   payload type parameter lets one module serve pixels and weights
 */

`timescale 1ns/1ps

module step_buffer import conv_pkg::*; #(
    parameter type payload_t  = logic,
    parameter int  STEPS      = DEFAULT_KERNEL_W,
    parameter int  STEP_DELAY = DEFAULT_STEP_DELAY
)(
    input  logic     aclk,
    input  logic     reset,
    input  logic     enable,

    input  logic     in_valid    [STEPS-1:0],
    input  payload_t in_payload  [STEPS-1:0],

    output logic     out_valid   [STEPS-1:0],
    output payload_t out_payload [STEPS-1:0]
);

    genvar k;
    generate
        for (k = 0; k < STEPS; k++) begin : lane_gen
            if (k == 0) begin : pass_gen
                // first lane has no delay at all
                assign out_valid[k]   = in_valid[k];
                assign out_payload[k] = in_payload[k];
            end else begin : delay_gen
                localparam int DEPTH = k * STEP_DELAY;

                // tap DEPTH-1 is the lane output
                logic     valid_q [DEPTH-1:0];
                payload_t data_q  [DEPTH-1:0];

                // valid bits of the line are cleared on reset
                always_ff @(posedge aclk) begin
                    if (reset) begin
                        for (int i = 0; i < DEPTH; i++) begin
                            valid_q[i] <= 1'b0;
                        end
                    end else if (enable) begin
                        valid_q[0] <= in_valid[k];
                        for (int i = 1; i < DEPTH; i++) begin
                            valid_q[i] <= valid_q[i-1];
                        end
                    end
                end

                // payload moves along with its valid bit
                always_ff @(posedge aclk) begin
                    if (enable) begin
                        data_q[0] <= in_payload[k];
                        for (int i = 1; i < DEPTH; i++) begin
                            data_q[i] <= data_q[i-1];
                        end
                    end
                end

                assign out_valid[k]   = valid_q[DEPTH-1];
                assign out_payload[k] = data_q[DEPTH-1];
            end
        end
    endgenerate

endmodule

// ==== design/conv_pkg.sv ====
/*
 * shared definitions of the convolution unit
 *   element widths: pixel, weight, accumulated sum, block tag
 *   element types built on those widths
 *   packed payload of one pixel lane
 *   default values of the module parameters
 */

package conv_pkg;

    // element widths
    localparam int PIXEL_WIDTH  = 8;
    localparam int WEIGHT_WIDTH = 8;
    // result wraps modulo 2^SUM_WIDTH
    localparam int SUM_WIDTH    = 32;
    localparam int USER_WIDTH   = 4;

    // defaults for the parameters that conv_unit passes down
    localparam int DEFAULT_KERNEL_W   = 3;
    // cycles between neighbouring lanes, at least 2
    localparam int DEFAULT_STEP_DELAY = 2;
    // depth of the multiplier pipeline
    localparam int DEFAULT_MUL_DELAY  = 3;

    // signed operands and result
    typedef logic signed [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [SUM_WIDTH-1:0]    sum_t;

    // block tag, plain unsigned bits
    typedef logic [USER_WIDTH-1:0] user_t;

    // one beat of a pixel lane, 13 bits
    // last marks the final beat of a block
    // user is the block tag, only meaningful with last
    typedef struct packed {
        pixel_t pixel;
        logic   last;
        user_t  user;
    } pixel_lane_t;

endpackage
